// File: common/isa_pkg.sv
`default_nettype none

package isa_pkg;

  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_reg    = 7'b0110011;
  localparam logic [6:0] op_system = 7'b1110011;

  // alu funct3
  localparam logic [2:0] f3_add  = 3'b000;
  localparam logic [2:0] f3_sll  = 3'b001;
  localparam logic [2:0] f3_slt  = 3'b010;
  localparam logic [2:0] f3_sltu = 3'b011;
  localparam logic [2:0] f3_xor  = 3'b100;
  localparam logic [2:0] f3_sr   = 3'b101;  // srl / sra by funct7
  localparam logic [2:0] f3_or   = 3'b110;
  localparam logic [2:0] f3_and  = 3'b111;

  // branch funct3
  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  // system funct3 and funct12
  localparam logic [2:0]  f3_priv   = 3'b000;
  localparam logic [2:0]  f3_csrrw  = 3'b001;
  localparam logic [2:0]  f3_csrrs  = 3'b010;
  localparam logic [11:0] f12_ecall  = 12'h000;
  localparam logic [11:0] f12_ebreak = 12'h001;
  localparam logic [11:0] f12_mret   = 12'h302;

  localparam logic [11:0] csr_mtvec  = 12'h305;
  localparam logic [11:0] csr_mepc   = 12'h341;
  localparam logic [11:0] csr_mcause = 12'h342;

  localparam logic [31:0] ecall_cause = 32'd11;  // env call from M-mode

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  // one instruction word, six ways to read it
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    b_fmt_t b_fmt;
    u_fmt_t u_fmt;
    j_fmt_t j_fmt;
  } instr_t;

endpackage

`default_nettype wire

// File: common/core_pkg.sv
`default_nettype none

package core_pkg;

  localparam logic [31:0] reset_pc = 32'h8000_0000;

  localparam int imem_words = 256;
  localparam int dmem_words = 256;
  localparam int imem_aw    = $clog2(imem_words);
  localparam int dmem_aw    = $clog2(dmem_words);

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_b
  } alu_op_e;

  typedef enum logic [2:0] {
    npc_seq,
    npc_jal,
    npc_jalr,
    npc_branch,
    npc_trap,
    npc_mret
  } npc_sel_e;

  typedef enum logic [2:0] {
    wb_alu,
    wb_pc4,
    wb_mem,
    wb_csr
  } wb_sel_e;

  typedef enum logic [1:0] {
    op2_rs2,
    op2_imm,
    op2_csr
  } op2_sel_e;

  // same encoding as load/store funct3[1:0]
  typedef enum logic [1:0] {
    size_byte = 2'b00,
    size_half = 2'b01,
    size_word = 2'b10
  } mem_size_e;

endpackage

`default_nettype wire

// File: design/ifu.sv
`default_nettype none

module ifu (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          halt,
  input  core_pkg::npc_sel_e            npc_sel,
  input  logic [31:0]                   imm,
  input  logic [31:0]                   alu_result,
  input  logic                          branch_taken,  // compare bit from alu
  input  logic [31:0]                   csr_mtvec,
  input  logic [31:0]                   csr_mepc,
  input  logic                          imem_we,
  input  logic [core_pkg::imem_aw-1:0]  imem_addr,
  input  logic [31:0]                   imem_wdata,
  output logic [31:0]                   pc,
  output isa_pkg::instr_t               inst
);
  import core_pkg::*;
  import isa_pkg::*;

  logic [31:0] imem [imem_words];
  logic [31:0] next_pc;
  logic        taken;

  always_ff @(posedge clk) begin
    if (imem_we) imem[imem_addr] <= imem_wdata;
  end

  assign inst = imem[pc[imem_aw+1:2]];

  // beq/bne come through as sub, the rest as slt/sltu
  always_comb begin
    case (inst.b_fmt.funct3)
      f3_beq:           taken = (alu_result == '0);
      f3_bne:           taken = (alu_result != '0);
      f3_blt, f3_bltu:  taken = branch_taken;
      f3_bge, f3_bgeu:  taken = !branch_taken;
      default:          taken = 1'b0;
    endcase
  end

  always_comb begin
    case (npc_sel)
      npc_jal:    next_pc = pc + imm;
      npc_jalr:   next_pc = alu_result & ~32'd1;
      npc_branch: next_pc = taken ? pc + imm : pc + 32'd4;
      npc_trap:   next_pc = csr_mtvec;
      npc_mret:   next_pc = csr_mepc;
      default:    next_pc = pc + 32'd4;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) pc <= reset_pc;
    else if (!halt) pc <= next_pc;  // ebreak freezes fetch
  end

endmodule

`default_nettype wire

// File: idu/idu.sv
`default_nettype none

module idu (
  input  isa_pkg::instr_t       inst,
  output logic [31:0]           imm,
  output logic [4:0]            rs1,
  output logic [4:0]            rs2,
  output logic [4:0]            rd,
  output logic                  r_wen,
  output core_pkg::wb_sel_e     wb_sel,
  output core_pkg::op2_sel_e    op2_sel,
  output logic                  op1_pc,
  output core_pkg::alu_op_e     alu_op,
  output core_pkg::npc_sel_e    npc_sel,
  output logic                  mem_ren,
  output logic                  mem_wen,
  output core_pkg::mem_size_e   mem_size,
  output logic                  mem_sext,
  output logic [11:0]           csr_addr,
  output logic                  csr_wen,
  output logic                  ecall,
  output logic                  halt
);
  import core_pkg::*;
  import isa_pkg::*;

  logic [2:0] funct3;
  logic       alt;  // funct7 bit 5
  logic       wen;

  function automatic alu_op_e alu_from_f3(input logic [2:0] f3, input logic sub_sra);
    alu_op_e op;
    case (f3)
      f3_add:  op = sub_sra ? alu_sub : alu_add;
      f3_sll:  op = alu_sll;
      f3_slt:  op = alu_slt;
      f3_sltu: op = alu_sltu;
      f3_xor:  op = alu_xor;
      f3_sr:   op = sub_sra ? alu_sra : alu_srl;
      f3_or:   op = alu_or;
      default: op = alu_and;
    endcase
    return op;
  endfunction

  assign funct3   = inst.r_fmt.funct3;
  assign alt      = inst.r_fmt.funct7[5];
  assign rs1      = inst.r_fmt.rs1;
  assign rs2      = inst.r_fmt.rs2;
  assign rd       = inst.r_fmt.rd;
  assign csr_addr = inst.i_fmt.imm;
  assign r_wen    = wen && (rd != 5'd0);  // x0 stays zero

  always_comb begin
    imm      = '0;
    wen      = 1'b0;
    wb_sel   = wb_alu;
    op2_sel  = op2_rs2;
    op1_pc   = 1'b0;
    alu_op   = alu_add;
    npc_sel  = npc_seq;
    mem_ren  = 1'b0;
    mem_wen  = 1'b0;
    mem_size = mem_size_e'(funct3[1:0]);
    mem_sext = !funct3[2];
    csr_wen  = 1'b0;
    ecall    = 1'b0;
    halt     = 1'b0;
    case (inst.r_fmt.opcode)
      op_lui, op_auipc: begin
        imm     = {inst.u_fmt.imm, 12'b0};
        wen     = 1'b1;
        op2_sel = op2_imm;
        op1_pc  = (inst.r_fmt.opcode == op_auipc);
        alu_op  = op1_pc ? alu_add : alu_pass_b;
      end
      op_jal: begin
        imm     = {{11{inst.j_fmt.imm20}}, inst.j_fmt.imm20, inst.j_fmt.imm19_12,
                   inst.j_fmt.imm11, inst.j_fmt.imm10_1, 1'b0};
        wen     = 1'b1;
        wb_sel  = wb_pc4;
        npc_sel = npc_jal;
      end
      op_jalr: begin
        imm     = {{20{inst.i_fmt.imm[11]}}, inst.i_fmt.imm};
        wen     = 1'b1;
        wb_sel  = wb_pc4;
        op2_sel = op2_imm;
        npc_sel = npc_jalr;
      end
      op_branch: begin
        imm     = {{19{inst.b_fmt.imm12}}, inst.b_fmt.imm12, inst.b_fmt.imm11,
                   inst.b_fmt.imm10_5, inst.b_fmt.imm4_1, 1'b0};
        npc_sel = npc_branch;
        if (funct3[2]) alu_op = funct3[1] ? alu_sltu : alu_slt;
        else alu_op = alu_sub;
      end
      op_load: begin
        imm     = {{20{inst.i_fmt.imm[11]}}, inst.i_fmt.imm};
        wen     = 1'b1;
        wb_sel  = wb_mem;
        op2_sel = op2_imm;
        mem_ren = 1'b1;
      end
      op_store: begin
        imm     = {{20{inst.s_fmt.imm_hi[6]}}, inst.s_fmt.imm_hi, inst.s_fmt.imm_lo};
        op2_sel = op2_imm;
        mem_wen = 1'b1;
      end
      op_imm: begin
        imm     = {{20{inst.i_fmt.imm[11]}}, inst.i_fmt.imm};
        wen     = 1'b1;
        op2_sel = op2_imm;
        alu_op  = alu_from_f3(funct3, alt && (funct3 == f3_sr));
      end
      op_reg: begin
        wen    = 1'b1;
        alu_op = alu_from_f3(funct3, alt);
      end
      op_system: begin
        case (funct3)
          f3_priv: begin
            ecall = (inst.i_fmt.imm == f12_ecall);
            halt  = (inst.i_fmt.imm == f12_ebreak);
            if (ecall) npc_sel = npc_trap;
            else if (inst.i_fmt.imm == f12_mret) npc_sel = npc_mret;
          end
          f3_csrrw: begin
            wen     = 1'b1;
            wb_sel  = wb_csr;
            op2_sel = op2_imm;  // rs1 + 0
            csr_wen = 1'b1;
          end
          f3_csrrs: begin
            wen     = 1'b1;
            wb_sel  = wb_csr;
            op2_sel = op2_csr;
            alu_op  = alu_or;
            csr_wen = 1'b1;
          end
          default: ;
        endcase
      end
      default: ;  // unknown opcode, no-op
    endcase
  end

endmodule

`default_nettype wire

// File: design/reg_heap.sv
`default_nettype none

module reg_heap (
  input  logic        clk,
  input  logic        rst,
  input  logic [4:0]  rs1,
  input  logic [4:0]  rs2,
  input  logic [4:0]  rd,
  input  logic        r_wen,
  input  logic [31:0] wdata,
  input  logic [11:0] csr_addr,
  input  logic        csr_wen,
  input  logic [31:0] csr_wdata,
  input  logic        ecall,
  input  logic [31:0] pc,
  output logic [31:0] src1,
  output logic [31:0] src2,
  output logic [31:0] csr_rdata,
  output logic [31:0] mtvec,
  output logic [31:0] mepc
);
  import isa_pkg::*;

  logic [31:0] rf [32];
  logic [31:0] mcause;

  assign src1 = rf[rs1];
  assign src2 = rf[rs2];

  always_comb begin
    case (csr_addr)
      csr_mtvec:  csr_rdata = mtvec;
      csr_mepc:   csr_rdata = mepc;
      csr_mcause: csr_rdata = mcause;
      default:    csr_rdata = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) rf[i] <= '0;
      mtvec  <= '0;
      mepc   <= '0;
      mcause <= '0;
    end else begin
      if (r_wen) rf[rd] <= wdata;
      if (ecall) begin
        mepc   <= pc;  // trap entry
        mcause <= ecall_cause;
      end else if (csr_wen) begin
        case (csr_addr)
          csr_mtvec:  mtvec  <= csr_wdata;
          csr_mepc:   mepc   <= csr_wdata;
          csr_mcause: mcause <= csr_wdata;
          default: ;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// File: design/alu.sv
`default_nettype none

module alu (
  input  core_pkg::alu_op_e op,
  input  logic [31:0]       a,
  input  logic [31:0]       b,
  output logic [31:0]       result
);
  import core_pkg::*;

  logic [4:0] shamt;

  assign shamt = b[4:0];

  always_comb begin
    case (op)
      alu_add:    result = a + b;
      alu_sub:    result = a - b;
      alu_sll:    result = a << shamt;
      alu_slt:    result = {31'd0, $signed(a) < $signed(b)};
      alu_sltu:   result = {31'd0, a < b};
      alu_xor:    result = a ^ b;
      alu_srl:    result = a >> shamt;
      alu_sra:    result = $unsigned($signed(a) >>> shamt);
      alu_or:     result = a | b;
      alu_and:    result = a & b;
      alu_pass_b: result = b;  // lui
      default:    result = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: lsu/lsu.sv
`default_nettype none

module lsu (
  input  logic                clk,
  input  logic                ren,
  input  logic                wen,
  input  core_pkg::mem_size_e size,
  input  logic                sext,
  input  logic [31:0]         addr,
  input  logic [31:0]         wdata,
  output logic [31:0]         rdata
);
  import core_pkg::*;

  logic [31:0]        mem [dmem_words];
  logic [dmem_aw-1:0] idx;
  logic [31:0]        word;
  logic [31:0]        wlane;  // store data copied to every lane
  logic [3:0]         be;
  logic [7:0]         rbyte;
  logic [15:0]        rhalf;

  assign idx  = addr[dmem_aw+1:2];
  assign word = mem[idx];

  always_comb begin
    case (size)
      size_byte: begin
        be    = 4'b0001 << addr[1:0];
        wlane = {4{wdata[7:0]}};
      end
      size_half: begin
        be    = addr[1] ? 4'b1100 : 4'b0011;
        wlane = {2{wdata[15:0]}};
      end
      default: begin
        be    = 4'b1111;
        wlane = wdata;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < 4; i++) begin
      if (wen && be[i]) mem[idx][i*8 +: 8] <= wlane[i*8 +: 8];
    end
  end

  assign rbyte = word[{addr[1:0], 3'b000} +: 8];
  assign rhalf = addr[1] ? word[31:16] : word[15:0];

  always_comb begin
    case (size)
      size_byte: rdata = {{24{sext & rbyte[7]}}, rbyte};
      size_half: rdata = {{16{sext & rhalf[15]}}, rhalf};
      default:   rdata = word;
    endcase
    if (!ren) rdata = '0;
  end

endmodule

`default_nettype wire

// File: design/npc.sv
`default_nettype none

module npc (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         imem_we,
  input  logic [core_pkg::imem_aw-1:0] imem_addr,
  input  logic [31:0]                  imem_wdata,
  output logic [31:0]                  pc,
  output logic                         halt,
  output logic                         commit_wen,
  output logic [4:0]                   commit_rd,
  output logic [31:0]                  commit_data
);
  import core_pkg::*;
  import isa_pkg::*;

  instr_t      inst;
  logic [31:0] imm;
  logic [4:0]  rs1, rs2, rd;
  logic        r_wen;
  wb_sel_e     wb_sel;
  op2_sel_e    op2_sel;
  logic        op1_pc;
  alu_op_e     alu_op;
  npc_sel_e    npc_sel;
  logic        mem_ren, mem_wen, mem_sext;
  mem_size_e   mem_size;
  logic [11:0] csr_addr;
  logic        csr_wen, ecall;
  logic [31:0] src1, src2, csr_rdata, mtvec, mepc;
  logic [31:0] alu_a, alu_b, alu_result;
  logic [31:0] mem_rdata, wb_data;

  assign alu_a = op1_pc ? pc : src1;  // auipc

  always_comb begin
    case (op2_sel)
      op2_imm: alu_b = imm;
      op2_csr: alu_b = csr_rdata;
      default: alu_b = src2;
    endcase
  end

  always_comb begin
    case (wb_sel)
      wb_pc4:  wb_data = pc + 32'd4;  // link
      wb_mem:  wb_data = mem_rdata;
      wb_csr:  wb_data = csr_rdata;
      default: wb_data = alu_result;
    endcase
  end

  assign commit_wen  = r_wen;
  assign commit_rd   = rd;
  assign commit_data = wb_data;

  ifu u_ifu (
    .clk(clk), .rst(rst), .halt(halt), .npc_sel(npc_sel), .imm(imm),
    .alu_result(alu_result), .branch_taken(alu_result[0]),
    .csr_mtvec(mtvec), .csr_mepc(mepc),
    .imem_we(imem_we), .imem_addr(imem_addr), .imem_wdata(imem_wdata),
    .pc(pc), .inst(inst)
  );

  idu u_idu (
    .inst(inst), .imm(imm), .rs1(rs1), .rs2(rs2), .rd(rd), .r_wen(r_wen),
    .wb_sel(wb_sel), .op2_sel(op2_sel), .op1_pc(op1_pc), .alu_op(alu_op),
    .npc_sel(npc_sel), .mem_ren(mem_ren), .mem_wen(mem_wen),
    .mem_size(mem_size), .mem_sext(mem_sext), .csr_addr(csr_addr),
    .csr_wen(csr_wen), .ecall(ecall), .halt(halt)
  );

  reg_heap u_reg_heap (
    .clk(clk), .rst(rst), .rs1(rs1), .rs2(rs2), .rd(rd), .r_wen(r_wen),
    .wdata(wb_data), .csr_addr(csr_addr), .csr_wen(csr_wen),
    .csr_wdata(alu_result), .ecall(ecall), .pc(pc),
    .src1(src1), .src2(src2), .csr_rdata(csr_rdata), .mtvec(mtvec), .mepc(mepc)
  );

  alu u_alu (
    .op(alu_op), .a(alu_a), .b(alu_b), .result(alu_result)
  );

  lsu u_lsu (
    .clk(clk), .ren(mem_ren), .wen(mem_wen), .size(mem_size), .sext(mem_sext),
    .addr(alu_result), .wdata(src2), .rdata(mem_rdata)
  );

endmodule

`default_nettype wire

// File: tests/npc_asserts.sv
`default_nettype none

module npc_asserts (
  input logic        clk,
  input logic        rst,
  input logic [31:0] pc,
  input logic        halt,
  input logic        commit_wen,
  input logic [4:0]  commit_rd
);

  pc_aligned: assert property (
    @(posedge clk) disable iff (rst)
    pc[1:0] == 2'b00
  ) else $error("pc is not word aligned: %h", pc);

  // x0 writes are gated in the decoder
  commit_rd_nonzero: assert property (
    @(posedge clk) disable iff (rst)
    commit_wen |-> commit_rd != 5'd0
  ) else $error("register write retired with rd equal to zero");

  halt_holds: assert property (
    @(posedge clk) disable iff (rst)
    halt |=> halt && $stable(pc)
  ) else $error("core left the halted state or pc moved, pc %h", pc);

endmodule

`default_nettype wire

// File: tests/npc_tb.sv
`default_nettype none

module npc_tb;

  // RV32I major opcodes
  localparam logic [6:0] opc_lui    = 7'h37;
  localparam logic [6:0] opc_auipc  = 7'h17;
  localparam logic [6:0] opc_imm    = 7'h13;
  localparam logic [6:0] opc_reg    = 7'h33;
  localparam logic [6:0] opc_load   = 7'h03;
  localparam logic [6:0] opc_store  = 7'h23;
  localparam logic [6:0] opc_branch = 7'h63;
  localparam logic [6:0] opc_jal    = 7'h6f;
  localparam logic [6:0] opc_jalr   = 7'h67;
  localparam logic [6:0] opc_sys    = 7'h73;

  localparam logic [31:0] ecall_word  = 32'h0000_0073;
  localparam logic [31:0] ebreak_word = 32'h0010_0073;
  localparam logic [31:0] mret_word   = 32'h3020_0073;
  localparam logic [31:0] base_pc     = 32'h8000_0000;
  localparam int          max_rows    = 64;

  logic        clk;
  logic        rst;
  logic        imem_we;
  logic [7:0]  imem_addr;
  logic [31:0] imem_wdata;
  logic [31:0] pc;
  logic        halt;
  logic        commit_wen;
  logic [4:0]  commit_rd;
  logic [31:0] commit_data;

  // program table with one row per executed instruction
  int          row_addr [max_rows];
  logic [31:0] row_word [max_rows];
  logic [31:0] row_pc   [max_rows];
  logic        row_wen  [max_rows];
  logic [4:0]  row_rd   [max_rows];
  logic [31:0] row_data [max_rows];
  int          n_rows;

  npc dut0 (
    .clk(clk), .rst(rst), .imem_we(imem_we), .imem_addr(imem_addr),
    .imem_wdata(imem_wdata), .pc(pc), .halt(halt), .commit_wen(commit_wen),
    .commit_rd(commit_rd), .commit_data(commit_data)
  );

  bind npc npc_asserts asserts0 (
    .clk(clk), .rst(rst), .pc(pc), .halt(halt),
    .commit_wen(commit_wen), .commit_rd(commit_rd)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, opc_reg};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], opc_store};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], opc_branch};
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                        input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, opc_jal};
  endfunction

  task automatic add_row(input int addr, input logic [31:0] word, input logic wen,
                         input logic [4:0] rd, input logic [31:0] data);
    row_addr[n_rows] = addr;
    row_word[n_rows] = word;
    row_pc[n_rows]   = base_pc + (32'(addr) << 2);
    row_wen[n_rows]  = wen;
    row_rd[n_rows]   = rd;
    row_data[n_rows] = data;
    n_rows++;
  endtask

  task automatic abort_run();
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_equal(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("[FAIL] %s expected %h actual %h", name, expected, actual);
      abort_run();
    end
  endtask

  task automatic build_program();
    add_row(0, enc_i(12'd5, 5'd0, 3'b000, 5'd1, opc_imm), 1'b1, 5'd1, 32'd5);
    add_row(1, enc_i(12'hffd, 5'd0, 3'b000, 5'd2, opc_imm), 1'b1, 5'd2, 32'hffff_fffd);
    add_row(2, enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3), 1'b1, 5'd3, 32'd2);
    add_row(3, enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd4), 1'b1, 5'd4, 32'd8);
    add_row(4, enc_u(20'h12345, 5'd5, opc_lui), 1'b1, 5'd5, 32'h1234_5000);
    add_row(5, enc_u(20'h00001, 5'd6, opc_auipc), 1'b1, 5'd6, 32'h8000_1014);
    add_row(6, enc_r(7'h00, 5'd2, 5'd1, 3'b100, 5'd7), 1'b1, 5'd7, 32'hffff_fff8);
    add_row(7, enc_r(7'h00, 5'd2, 5'd1, 3'b110, 5'd8), 1'b1, 5'd8, 32'hffff_fffd);
    add_row(8, enc_r(7'h00, 5'd2, 5'd1, 3'b111, 5'd9), 1'b1, 5'd9, 32'd5);
    add_row(9, enc_i(12'h004, 5'd1, 3'b001, 5'd10, opc_imm), 1'b1, 5'd10, 32'h50);
    add_row(10, enc_i(12'h401, 5'd2, 3'b101, 5'd11, opc_imm), 1'b1, 5'd11, 32'hffff_fffe);
    add_row(11, enc_i(12'd28, 5'd2, 3'b101, 5'd12, opc_imm), 1'b1, 5'd12, 32'hf);
    add_row(12, enc_r(7'h00, 5'd1, 5'd2, 3'b010, 5'd13), 1'b1, 5'd13, 32'd1);
    add_row(13, enc_r(7'h00, 5'd1, 5'd2, 3'b011, 5'd14), 1'b1, 5'd14, 32'd0);
    add_row(14, enc_i(12'd7, 5'd1, 3'b000, 5'd0, opc_imm), 1'b0, 5'd0, 32'd0);  // x0
    add_row(15, enc_r(7'h00, 5'd1, 5'd1, 3'b001, 5'd15), 1'b1, 5'd15, 32'ha0);
    // stores then loads at 0x100
    add_row(16, enc_u(20'h87654, 5'd16, opc_lui), 1'b1, 5'd16, 32'h8765_4000);
    add_row(17, enc_i(12'h3a9, 5'd16, 3'b000, 5'd16, opc_imm), 1'b1, 5'd16, 32'h8765_43a9);
    add_row(18, enc_s(12'h100, 5'd16, 5'd0, 3'b010), 1'b0, 5'd0, 32'd0);
    add_row(19, enc_s(12'h101, 5'd2, 5'd0, 3'b000), 1'b0, 5'd0, 32'd0);
    add_row(20, enc_s(12'h102, 5'd1, 5'd0, 3'b001), 1'b0, 5'd0, 32'd0);
    add_row(21, enc_i(12'h101, 5'd0, 3'b000, 5'd17, opc_load), 1'b1, 5'd17, 32'hffff_fffd);
    add_row(22, enc_i(12'h101, 5'd0, 3'b100, 5'd18, opc_load), 1'b1, 5'd18, 32'h0000_00fd);
    add_row(23, enc_i(12'h100, 5'd0, 3'b001, 5'd19, opc_load), 1'b1, 5'd19, 32'hffff_fda9);
    add_row(24, enc_i(12'h100, 5'd0, 3'b101, 5'd20, opc_load), 1'b1, 5'd20, 32'h0000_fda9);
    add_row(25, enc_i(12'h100, 5'd0, 3'b010, 5'd21, opc_load), 1'b1, 5'd21, 32'h0005_fda9);
    add_row(26, enc_i(12'h102, 5'd0, 3'b001, 5'd22, opc_load), 1'b1, 5'd22, 32'h0000_0005);
    // branches and jumps
    add_row(27, enc_b(13'd8, 5'd2, 5'd1, 3'b000), 1'b0, 5'd0, 32'd0);  // beq not taken
    add_row(28, enc_b(13'd8, 5'd1, 5'd2, 3'b100), 1'b0, 5'd0, 32'd0);  // blt taken
    add_row(30, enc_b(13'd8, 5'd1, 5'd1, 3'b000), 1'b0, 5'd0, 32'd0);
    add_row(32, enc_j(21'd12, 5'd23), 1'b1, 5'd23, 32'h8000_0084);
    add_row(35, enc_u(20'h0, 5'd24, opc_auipc), 1'b1, 5'd24, 32'h8000_008c);
    add_row(36, enc_i(12'd17, 5'd24, 3'b000, 5'd25, opc_jalr), 1'b1, 5'd25, 32'h8000_0094);
    add_row(39, enc_b(13'd8, 5'd2, 5'd1, 3'b100), 1'b0, 5'd0, 32'd0);  // blt not taken
    // trap handler lives at word 56
    add_row(40, enc_u(20'h0, 5'd26, opc_auipc), 1'b1, 5'd26, 32'h8000_00a0);
    add_row(41, enc_i(12'h040, 5'd26, 3'b000, 5'd26, opc_imm), 1'b1, 5'd26, 32'h8000_00e0);
    add_row(42, enc_i(12'h305, 5'd26, 3'b001, 5'd27, opc_sys), 1'b1, 5'd27, 32'd0);
    add_row(43, ecall_word, 1'b0, 5'd0, 32'd0);
    add_row(56, enc_i(12'h341, 5'd0, 3'b010, 5'd28, opc_sys), 1'b1, 5'd28, 32'h8000_00ac);
    add_row(57, enc_i(12'h342, 5'd0, 3'b010, 5'd29, opc_sys), 1'b1, 5'd29, 32'd11);
    add_row(58, enc_i(12'h305, 5'd0, 3'b010, 5'd30, opc_sys), 1'b1, 5'd30, 32'h8000_00e0);
    add_row(59, enc_i(12'd4, 5'd28, 3'b000, 5'd28, opc_imm), 1'b1, 5'd28, 32'h8000_00b0);
    add_row(60, enc_i(12'h341, 5'd28, 3'b001, 5'd0, opc_sys), 1'b0, 5'd0, 32'd0);
    add_row(61, mret_word, 1'b0, 5'd0, 32'd0);
    add_row(44, enc_r(7'h00, 5'd1, 5'd29, 3'b000, 5'd31), 1'b1, 5'd31, 32'd16);
    add_row(45, ebreak_word, 1'b0, 5'd0, 32'd0);
  endtask

  task automatic load_program();
    for (int i = 0; i < n_rows; i++) begin
      @(posedge clk);
      #1;
      imem_we    = 1'b1;
      imem_addr  = row_addr[i][7:0];
      imem_wdata = row_word[i];
    end
    @(posedge clk);
    #1 imem_we = 1'b0;
  endtask

  task automatic run_program();
    for (int i = 0; i < n_rows; i++) begin
      @(negedge clk);  // outputs settled mid-cycle
      check_equal($sformatf("row %0d pc", i), row_pc[i], pc);
      check_equal($sformatf("row %0d commit_wen", i), 32'(row_wen[i]), 32'(commit_wen));
      check_equal($sformatf("row %0d halt", i), 32'(row_word[i] == ebreak_word), 32'(halt));
      if (row_wen[i]) begin
        check_equal($sformatf("row %0d commit_rd", i), 32'(row_rd[i]), 32'(commit_rd));
        check_equal($sformatf("row %0d commit_data", i), row_data[i], commit_data);
      end
    end
  endtask

  task automatic wait_for_halt();
    int cycles;
    cycles = 0;
    while (halt !== 1'b1 && cycles < 16) begin
      @(negedge clk);
      cycles++;
    end
    if (halt !== 1'b1) begin
      $display("timeout: the core never halted after the ebreak");
      abort_run();
    end
    // pc frozen for three more cycles
    for (int i = 0; i < 3; i++) begin
      @(negedge clk);
      check_equal($sformatf("halted cycle %0d halt", i), 32'd1, 32'(halt));
      check_equal($sformatf("halted cycle %0d pc", i), row_pc[n_rows-1], pc);
      check_equal($sformatf("halted cycle %0d commit_wen", i), 32'd0, 32'(commit_wen));
    end
  endtask

  initial begin
    rst        = 1'b1;
    imem_we    = 1'b0;
    imem_addr  = '0;
    imem_wdata = '0;
    n_rows     = 0;
    build_program();
    load_program();
    repeat (4) @(posedge clk);
    #1 rst = 1'b0;
    run_program();
    wait_for_halt();
    $display("Simulation passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: npc.f
common/isa_pkg.sv
common/core_pkg.sv
design/ifu.sv
idu/idu.sv
design/reg_heap.sv
design/alu.sv
lsu/lsu.sv
design/npc.sv
tests/npc_asserts.sv
tests/npc_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
  --top-module npc_tb -f npc.f -o npc_sim --Mdir obj_dir

./obj_dir/npc_sim > sim.log 2>&1 || true
cat sim.log

# exits non-zero when the pass line is missing
grep -q "Simulation passed" sim.log
